// File: Bender.yml
package:
  name: video_colmix

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/colmix_pkg.sv
      - hw/cpu_bus_pkg.sv
      - hw/layer_priority.sv
      - hw/palette_ram.sv
      - hw/shade_unit.sv
      - hw/blank_delay.sv
      - hw/video_colmix.sv
      - target: test
        files:
          - verification/colmix_tb.sv

// File: hw/blank_delay.sv
// blanking alignment stage, delays blanks and colour and forces black while blanked
`timescale 1ns/1ps
`include "colmix_macros.svh"

module blank_delay (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    input  logic             pre_lhbl,
    input  logic             pre_lvbl,
    input  colmix_pkg::rgb_t rgb_in,
    output logic             lhbl,
    output logic             lvbl,
    output colmix_pkg::rgb_t rgb
);

    import colmix_pkg::*;

    // blanks skip the priority and shade stages, so they need two more taps
    localparam int BLANK_STAGES = `COLMIX_BLANK_DLY + 2;

    logic [BLANK_STAGES-1:0]          hbl_sr;
    logic [BLANK_STAGES-1:0]          vbl_sr;
    rgb_t [`COLMIX_BLANK_DLY-1:0]     col_sr;
    logic                             active;

    // both blanks are active low, high means visible
    assign active = hbl_sr[BLANK_STAGES-1] && vbl_sr[BLANK_STAGES-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
            col_sr <= '0;
            lhbl   <= 1'b0;
            lvbl   <= 1'b0;
            rgb    <= '0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[BLANK_STAGES-2:0], pre_lhbl};
            vbl_sr <= {vbl_sr[BLANK_STAGES-2:0], pre_lvbl};
            col_sr[0] <= rgb_in;
            for (int i = 1; i < `COLMIX_BLANK_DLY; i++) begin
                col_sr[i] <= col_sr[i-1];
            end
            // output stage, blanks and colour line up here
            lhbl <= hbl_sr[BLANK_STAGES-1];
            lvbl <= vbl_sr[BLANK_STAGES-1];
            rgb  <= active ? col_sr[`COLMIX_BLANK_DLY-1] : '0;
        end
    end

endmodule

// File: hw/colmix_pkg.sv
// video pixel-path types of the colour mixer, imported by the RTL blocks and the testbench
`include "colmix_macros.svh"

package colmix_pkg;

    // one pixel from every layer generator, sampled together on pxl_cen
    typedef struct packed {
        logic [10:0] tmap_addr;   // tile mapper palette index
        logic [13:0] obj_pxl;     // sprite pixel incl. priority bits
        logic [7:0]  road_pxl;
        logic        rc3;         // road control
        logic        sa;
        logic        sb;
        logic        fix;         // fixed text layer on top
        logic        shadow;
    } layer_in_t;

    // final colour, red in the upper bits
    typedef struct packed {
        logic [`COLMIX_COLOR_W-1:0] red;
        logic [`COLMIX_COLOR_W-1:0] green;
        logic [`COLMIX_COLOR_W-1:0] blue;
    } rgb_t;

    // layer picked by the priority equations
    typedef enum logic [1:0] {
        LAYER_ROAD,
        LAYER_TILE,
        LAYER_OBJ
    } layer_sel_e;

    // shadow / highlight mode
    typedef enum logic [1:0] {
        SHADE_NONE,
        SHADE_DIM,
        SHADE_LIGHT
    } shade_e;

endpackage

// File: hw/cpu_bus_pkg.sv
// cpu-side palette bus request type, imported wherever the palette port is driven
`include "colmix_macros.svh"

package cpu_bus_pkg;

    // one palette access from the cpu
    // strobes are active low, bit 1 is the upper byte
    typedef struct packed {
        logic                      cs;
        logic [1:0]                dsn;
        logic [`COLMIX_CPU_AW-1:0] addr;
        logic [`COLMIX_DATA_W-1:0] wdata;
    } cpu_req_t;

endpackage

// File: hw/layer_priority.sv
// layer priority mux, picks road, tile or sprite pixel and registers the palette address
`timescale 1ns/1ps
`include "colmix_macros.svh"

module layer_priority (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  colmix_pkg::layer_in_t     layer,
    output logic [`COLMIX_PAL_AW-1:0] pal_addr,
    output logic                      shadow_q
);

    import colmix_pkg::*;

    // sprite pixel from the previous enable
    logic [13:0]               obj_q;
    logic                      road_hit;
    layer_sel_e                sel;
    logic [`COLMIX_PAL_AW-1:0] addr_d;

    // road wins only when fix is clear and the held sprite is transparent
    // or carries the road-through code
    always_comb begin
        road_hit = !layer.fix && (
            (obj_q[3:0] == 4'h0 && (!layer.rc3 || (!layer.sa && !layer.sb))) ||
            (obj_q[11:10] == 2'b10 && obj_q[3:0] == 4'b0101));
        if (road_hit) begin
            sel = LAYER_ROAD;
        end else if (layer.sa || layer.sb || layer.fix) begin
            sel = LAYER_TILE;
        end else begin
            sel = LAYER_OBJ;
        end
    end

    // palette address per layer
    always_comb begin
        case (sel)
            LAYER_ROAD: begin
                // road colours sit in the 0x400 block, bit 7 sign-extended
                addr_d = {2'b01, {3{layer.road_pxl[7]}}, layer.road_pxl[6:0]};
            end
            LAYER_TILE: begin
                addr_d = {1'b0, layer.tmap_addr};
            end
            default: begin
                // skip the sprite shadow and priority bits 6:4
                addr_d = {1'b1, layer.obj_pxl[13:7], layer.obj_pxl[3:0]};
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_q    <= '0;
            pal_addr <= '0;
            shadow_q <= 1'b0;
        end else if (pxl_cen) begin
            obj_q    <= layer.obj_pxl;
            pal_addr <= addr_d;
            // shadow follows its pixel into the shade stage
            shadow_q <= layer.shadow;
        end
    end

endmodule

// File: hw/palette_ram.sv
// dual-port palette memory, cpu byte writes on one port and video reads on the other
`timescale 1ns/1ps
`include "colmix_macros.svh"

module palette_ram (
    input  logic                      clk,
    input  cpu_bus_pkg::cpu_req_t     cpu,
    output logic [`COLMIX_DATA_W-1:0] cpu_din,
    input  logic [`COLMIX_PAL_AW-1:0] pal_addr,
    output logic [`COLMIX_DATA_W-1:0] pal_word
);

    localparam int DEPTH = 1 << `COLMIX_CPU_AW;
    localparam int PAD_W = `COLMIX_CPU_AW - `COLMIX_PAL_AW;

    // byte lanes kept apart so each strobe writes its own array
    logic [7:0] mem_lo [DEPTH];
    logic [7:0] mem_hi [DEPTH];

    logic [1:0]                we;
    logic [`COLMIX_CPU_AW-1:0] vid_addr;
    logic [7:0]                rd_lo;
    logic [7:0]                rd_hi;

    // strobes are active low, gated by chip select
    assign we = ~cpu.dsn & {2{cpu.cs}};

    // video only reaches the lower half
    assign vid_addr = {{PAD_W{1'b0}}, pal_addr};

    // written lanes bypass the array so the merged word reads back at once
    assign rd_lo = we[0] ? cpu.wdata[7:0] : mem_lo[cpu.addr];
    assign rd_hi = we[1] ? cpu.wdata[15:8] : mem_hi[cpu.addr];

    // cpu port
    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem_lo[cpu.addr] <= cpu.wdata[7:0];
        end
        if (we[1]) begin
            mem_hi[cpu.addr] <= cpu.wdata[15:8];
        end
        cpu_din <= {rd_hi, rd_lo};
    end

    // video port, read only
    always_ff @(posedge clk) begin
        pal_word <= {mem_hi[vid_addr], mem_lo[vid_addr]};
    end

endmodule

// File: hw/shade_unit.sv
// shadow and highlight stage, unpacks the palette word and dims or lightens the colour
`timescale 1ns/1ps
`include "colmix_macros.svh"

module shade_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  logic [`COLMIX_DATA_W-1:0] pal_word,
    input  logic                      shadow,
    output colmix_pkg::rgb_t          shaded
);

    import colmix_pkg::*;

    logic [`COLMIX_COLOR_W-1:0] r_pal;
    logic [`COLMIX_COLOR_W-1:0] g_pal;
    logic [`COLMIX_COLOR_W-1:0] b_pal;
    shade_e                     mode;
    rgb_t                       shaded_d;

    // 3/4 of the value
    function automatic logic [`COLMIX_COLOR_W-1:0] dim(
        input logic [`COLMIX_COLOR_W-1:0] a
    );
        return a - (a >> 2);
    endfunction

    // 5/4 of the value, clipped at full scale
    function automatic logic [`COLMIX_COLOR_W-1:0] light(
        input logic [`COLMIX_COLOR_W-1:0] a
    );
        logic [`COLMIX_COLOR_W:0] sum;
        sum = {1'b0, a} + ({1'b0, a} >> 2);
        return sum[`COLMIX_COLOR_W] ? {`COLMIX_COLOR_W{1'b1}} : sum[`COLMIX_COLOR_W-1:0];
    endfunction

    // nibble per colour, bits 14:12 hold the extra lsbs
    assign r_pal = {pal_word[3:0], pal_word[12]};
    assign g_pal = {pal_word[7:4], pal_word[13]};
    assign b_pal = {pal_word[11:8], pal_word[14]};

    // bit 15 of the palette entry picks highlight over shadow
    always_comb begin
        if (!shadow) begin
            mode = SHADE_NONE;
        end else if (pal_word[15]) begin
            mode = SHADE_LIGHT;
        end else begin
            mode = SHADE_DIM;
        end
    end

    always_comb begin
        case (mode)
            SHADE_LIGHT: shaded_d = '{red: light(r_pal), green: light(g_pal), blue: light(b_pal)};
            SHADE_DIM:   shaded_d = '{red: dim(r_pal), green: dim(g_pal), blue: dim(b_pal)};
            default:     shaded_d = '{red: r_pal, green: g_pal, blue: b_pal};
        endcase
    end

    // ram data is settled one clk after the address, well before the next enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shaded <= '0;
        end else if (pxl_cen) begin
            shaded <= shaded_d;
        end
    end

endmodule

// File: hw/video_colmix.sv
// colour mixer top level, wires priority, palette, shade and blanking stages together
`timescale 1ns/1ps
`include "colmix_macros.svh"

module video_colmix (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  logic                      pre_lhbl,
    input  logic                      pre_lvbl,
    input  cpu_bus_pkg::cpu_req_t     cpu,
    output logic [`COLMIX_DATA_W-1:0] cpu_din,
    input  colmix_pkg::layer_in_t     layer,
    output colmix_pkg::rgb_t          rgb,
    output logic                      lhbl,
    output logic                      lvbl
);

    import colmix_pkg::*;

    logic [`COLMIX_PAL_AW-1:0] pal_addr;
    logic                      shadow_q;
    logic [`COLMIX_DATA_W-1:0] pal_word;
    rgb_t                      shaded;

    // stage N, layer select and palette address
    layer_priority layer_priority_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .layer    (layer),
        .pal_addr (pal_addr),
        .shadow_q (shadow_q)
    );

    // no arbitration, both ports run every clk
    palette_ram palette_ram_i (
        .clk      (clk),
        .cpu      (cpu),
        .cpu_din  (cpu_din),
        .pal_addr (pal_addr),
        .pal_word (pal_word)
    );

    // stage N+1
    shade_unit shade_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pal_word (pal_word),
        .shadow   (shadow_q),
        .shaded   (shaded)
    );

    // stages N+2 to N+4
    blank_delay blank_delay_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl),
        .rgb_in   (shaded),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .rgb      (rgb)
    );

endmodule

// File: include/colmix_macros.svh
// width and pipeline-depth macros for the colour mixer, included by the RTL and the testbench
`ifndef COLMIX_MACROS_SVH
`define COLMIX_MACROS_SVH

// palette address on the video side, 4K colours
`define COLMIX_PAL_AW 12

// cpu word address, 8K words
// video side only ever sees the lower half
`define COLMIX_CPU_AW 13

// palette word and cpu data bus
`define COLMIX_DATA_W 16

// one colour component, 4 palette bits plus the extra lsb
`define COLMIX_COLOR_W 5

// colour stages inside blank_delay
// priority and shade stages add two more, so 4 pixels in total
`define COLMIX_BLANK_DLY 2

`endif

// File: verification/colmix_tb.sv
// testbench for the colour mixer that replays the data file and checks colour and blanking
`timescale 1ns/1ps
`include "colmix_macros.svh"

module colmix_tb;

    import colmix_pkg::*;
    import cpu_bus_pkg::*;

    localparam int REC_W       = 80;
    localparam int REC_DEPTH   = 64;
    localparam int CEN_TIMEOUT = 16;
    localparam int FLUSH_LIMIT = 12;
    // enables between registering a pixel and seeing it on rgb
    localparam int PIPE_DEPTH  = 4;

    // record opcodes sit in the top nibble of each line
    typedef enum logic [3:0] {
        OP_END   = 4'h0,
        OP_WRITE = 4'h1,
        OP_READ  = 4'h2,
        OP_PIXEL = 4'h3
    } rec_op_e;

    // one pixel waiting for its result
    typedef struct packed {
        logic [31:0] target;
        logic [14:0] rgb;
        logic        lhbl;
        logic        lvbl;
        logic [7:0]  idx;
    } expect_t;

    logic                      clk;
    logic                      rst_n;
    logic                      pxl_cen;
    logic                      pre_lhbl;
    logic                      pre_lvbl;
    cpu_req_t                  cpu;
    logic [`COLMIX_DATA_W-1:0] cpu_din;
    layer_in_t                 layer;
    rgb_t                      rgb;
    logic                      lhbl;
    logic                      lvbl;

    logic [REC_W-1:0] recs [REC_DEPTH];
    expect_t          pending [$];
    logic [31:0]      cen_cnt;
    int               checked;
    integer           seed;
    logic [1:0]       cen_div;

    video_colmix dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl),
        .cpu      (cpu),
        .cpu_din  (cpu_din),
        .layer    (layer),
        .rgb      (rgb),
        .lhbl     (lhbl),
        .lvbl     (lvbl)
    );

    // 8 ns clock
    initial clk = 1'b0;
    always #4 clk = ~clk;

    // one enable every four clocks and updated just after the edge
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            cen_div = 2'd0;
            pxl_cen = 1'b0;
        end else begin
            pxl_cen = (cen_div == 2'd3);
            cen_div = cen_div + 2'd1;
        end
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_failure($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // returns just after the edge on which pxl_cen was high
    task automatic wait_pixel_enable();
        int  n;
        bit  seen;
        seen = 1'b0;
        for (n = 0; n < CEN_TIMEOUT && !seen; n++) begin
            @(posedge clk);
            if (pxl_cen) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            stop_on_failure("timed out waiting for a pixel enable");
        end
        cen_cnt = cen_cnt + 1;
    endtask

    // compare every pixel whose result is due on this enable
    task automatic check_due_pixels();
        expect_t e;
        while (pending.size() > 0 && pending[0].target <= cen_cnt) begin
            e = pending.pop_front();
            if (e.target != cen_cnt) begin
                stop_on_failure($sformatf("result of record %0d was never sampled", e.idx));
            end
            check_value($sformatf("record %0d rgb", e.idx), 32'(e.rgb), 32'(rgb));
            check_value($sformatf("record %0d lhbl", e.idx), 32'(e.lhbl), 32'(lhbl));
            check_value($sformatf("record %0d lvbl", e.idx), 32'(e.lvbl), 32'(lvbl));
            checked++;
        end
    endtask

    task automatic drive_cpu_write(input logic [REC_W-1:0] rec);
        cpu.cs    = 1'b1;
        cpu.dsn   = rec[73:72];
        cpu.addr  = rec[48:36];
        cpu.wdata = rec[15:0];
        @(posedge clk);
        #1;
        cpu.cs  = 1'b0;
        cpu.dsn = 2'b11;
    endtask

    // read data is registered and shows the word one clk after its address
    task automatic check_cpu_read(input logic [REC_W-1:0] rec, input int idx,
                                  input bit after_write);
        // same word was addressed by the write on the last clk
        if (after_write) begin
            check_value($sformatf("record %0d cpu_din after write", idx),
                        32'(rec[15:0]), 32'(cpu_din));
        end
        cpu.cs   = 1'b0;
        cpu.addr = rec[48:36];
        @(posedge clk);
        #1;
        check_value($sformatf("record %0d cpu_din", idx), 32'(rec[15:0]), 32'(cpu_din));
    endtask

    task automatic drive_pixel(input logic [REC_W-1:0] rec, input int idx);
        expect_t e;
        wait_pixel_enable();
        #1;
        check_due_pixels();
        pre_lhbl        = rec[75];
        pre_lvbl        = rec[74];
        layer.rc3       = rec[71];
        layer.sa        = rec[70];
        layer.sb        = rec[69];
        layer.fix       = rec[68];
        layer.shadow    = rec[64];
        layer.tmap_addr = rec[62:52];
        layer.obj_pxl   = rec[49:36];
        layer.road_pxl  = rec[35:28];
        // sprite bits 6:4 reach neither priority nor address
        layer.obj_pxl[6:4] = 3'($random(seed));
        // registered on the next enable and out PIPE_DEPTH enables after that
        e.target = cen_cnt + 1 + PIPE_DEPTH;
        e.rgb    = rec[14:0];
        e.lhbl   = rec[75];
        e.lvbl   = rec[74];
        e.idx    = idx[7:0];
        pending.push_back(e);
    endtask

    initial begin
        int  i;
        int  n;
        bit  done;
        bit  after_write;
        rst_n       = 1'b0;
        pxl_cen     = 1'b0;
        cen_div     = 2'd0;
        pre_lhbl    = 1'b0;
        pre_lvbl    = 1'b0;
        cpu         = '0;
        cpu.dsn     = 2'b11;
        layer       = '0;
        cen_cnt     = '0;
        checked     = 0;
        seed        = 32'h89cc73c5;
        done        = 1'b0;
        after_write = 1'b0;
        for (i = 0; i < REC_DEPTH; i++) begin
            recs[i] = '0;
        end
        $readmemh("verification/colmix_testdata.hex", recs);

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("reset rgb", 32'h0, 32'(rgb));
        check_value("reset lhbl", 32'h0, 32'(lhbl));
        check_value("reset lvbl", 32'h0, 32'(lvbl));
        // idle inputs are blanked, so the output stays black
        for (n = 0; n < 3; n++) begin
            wait_pixel_enable();
        end
        #1;
        check_value("idle rgb", 32'h0, 32'(rgb));
        check_value("idle lhbl", 32'h0, 32'(lhbl));
        check_value("idle lvbl", 32'h0, 32'(lvbl));

        for (i = 0; i < REC_DEPTH && !done; i++) begin
            after_write = (i > 0) && (recs[i-1][79:76] == OP_WRITE) &&
                          (recs[i-1][48:36] == recs[i][48:36]);
            case (rec_op_e'(recs[i][79:76]))
                OP_WRITE: drive_cpu_write(recs[i]);
                OP_READ:  check_cpu_read(recs[i], i, after_write);
                OP_PIXEL: drive_pixel(recs[i], i);
                OP_END:   done = 1'b1;
                default:  stop_on_failure($sformatf("record %0d has an unknown opcode", i));
            endcase
        end

        // drain the pixels still in the pipeline
        for (n = 0; n < FLUSH_LIMIT && pending.size() > 0; n++) begin
            wait_pixel_enable();
            #1;
            check_due_pixels();
        end

        if (pending.size() != 0 || checked == 0) begin
            stop_on_failure("pixel results missing at the end of the run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: verification/colmix_testdata.hex
// op 1 write: op dsn 00 000 addr(4) 00000 data(4); op 2 read: same with expected cpu_din
// op 3 pixel: op blank{lhbl,lvbl} flags{rc3,sa,sb,fix} shadow tmap(3) obj(4) road(2) 000 rgb(4)
10000000123000000321
10000000785000007654
10000000405000000A5F
10000000953000002B47
1000000020000000F0F8
10000000201000000C84
20000000953000002B47
10000001000000001234
20000001000000001234
1200000100000000ABCD
200000010000000012CD
11000001000000005678
200000010000000056CD
1300000100000000FFFF
200000010000000056CD
3C401230A8385000256D
3C401230805000000886
3CC01230000050007954
3C101230A83000000886
3C000000A83000003936
3C401230000000000886
3CA01230000000000886
3C80000000085000256D
3CC020000000000047E1
3CC120000000000057E1
3CC12010000000001992
3CC02010000000002218
34C01230000000000000
38C01230000000000000
30C01230000000000000
3CC01230000000000886
00000000000000000000

// File: verilog.f
+incdir+include
hw/colmix_pkg.sv
hw/cpu_bus_pkg.sv
hw/layer_priority.sv
hw/palette_ram.sv
hw/shade_unit.sv
hw/blank_delay.sv
hw/video_colmix.sv
verification/colmix_tb.sv
